// ==== list.f ====
source/rv_decode_pkg.sv
source/ir_splitter.sv
source/imm_extractor.sv
source/id_stage.sv
source/reg_file.sv
source/operand_stage.sv
source/decode_top.sv
test/tb_decode_top.sv

// ==== Bender.yml ====
package:
  name: rv_decode

sources:
  - source/rv_decode_pkg.sv
  - source/ir_splitter.sv
  - source/imm_extractor.sv
  - source/id_stage.sv
  - source/reg_file.sv
  - source/operand_stage.sv
  - source/decode_top.sv
  - target: simulation
    files:
      - test/tb_decode_top.sv

// ==== test/tb_decode_top.sv ====
`timescale 1ns/1ps

module tb_decode_top;

    localparam int IN_DEPTH     = 4;
    localparam int OUT_CREDITS  = 2;
    localparam int NUM          = 22;
    localparam int SETUP_CYCLES = 80;

    typedef struct packed {
        logic [4:0]  rd;
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [11:0] csr_addr;
        logic [31:0] imm;
        logic        wr_reg_n;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
    } bundle_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_instr;
    logic        in_credit;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        out_credit;
    logic        out_valid;
    logic [4:0]  out_rd;
    logic [6:0]  out_opcode;
    logic [2:0]  out_funct3;
    logic [6:0]  out_funct7;
    logic [11:0] out_csr_addr;
    logic [31:0] out_imm;
    logic        out_wr_reg_n;
    logic [31:0] out_rs1_data;
    logic [31:0] out_rs2_data;

    // Instruction table, expected bundles are derived from it
    logic [31:0] prog [NUM] = '{
        32'hFFF08293, 32'h00511313, 32'h41F1D393, 32'h00325413,  // addi -1, slli, srai, srli
        32'h00B504B3, 32'h40E68633, 32'hFF882783, 32'hFF192E23,  // add, sub, lw -8, sw -4
        32'hFF4988E3, 32'h016A9663, 32'hABCDEBB7, 32'h80000C17,  // beq -16, bne +12, lui, auipc
        32'h801FF0EF, 32'h064D0CE7, 32'h00001037, 32'h0080006F,  // jal -2048, jalr, lui x0, jal x0
        32'h00000013, 32'h305E1DF3, 32'hFFFFFFFF, 32'h01FF6EB3,  // nop, csrrw, unknown, or
        32'h7FF00FA3, 32'h0FF0000F                               // sb +2047, fence
    };
    bundle_t     expected [NUM];
    bundle_t     exp_q [$];
    bundle_t     exp_now;

    int          sent           = 0;
    int          issued         = 0;
    int          returned       = 0;
    int          credit_returns = 0;
    logic [31:0] rng_state      = 32'hbf6f;

    decode_top #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) decode_top_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_instr     (in_instr),
        .in_credit    (in_credit),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .out_credit   (out_credit),
        .out_valid    (out_valid),
        .out_rd       (out_rd),
        .out_opcode   (out_opcode),
        .out_funct3   (out_funct3),
        .out_funct7   (out_funct7),
        .out_csr_addr (out_csr_addr),
        .out_imm      (out_imm),
        .out_wr_reg_n (out_wr_reg_n),
        .out_rs1_data (out_rs1_data),
        .out_rs2_data (out_rs2_data)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Known register contents, x0 always zero
    function automatic logic [31:0] reg_value(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'h0;
        end
        return (32'h9e3779b9 * {27'b0, addr}) ^ {addr, 27'h0};
    endfunction

    function automatic logic [31:0] sign_extend(input logic [31:0] value, input int width);
        return $signed(value << (32 - width)) >>> (32 - width);
    endfunction

    function automatic bundle_t reference_decode(input logic [31:0] w);
        bundle_t b;
        logic    writes;
        b.rd       = w[11:7];
        b.opcode   = w[6:0];
        b.funct3   = w[14:12];
        b.funct7   = w[31:25];
        b.csr_addr = w[31:20];
        case (w[6:0])
            7'h37, 7'h17: b.imm = {w[31:12], 12'h000};
            7'h6f:        b.imm = sign_extend({w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
            7'h67, 7'h03: b.imm = sign_extend(w[31:20], 12);
            // Shifts by immediate have funct3 x01
            7'h13:        b.imm = (w[13:12] == 2'b01) ? {27'b0, w[24:20]} :
                                  sign_extend(w[31:20], 12);
            7'h63:        b.imm = sign_extend({w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
            7'h23:        b.imm = sign_extend({w[31:25], w[11:7]}, 12);
            default:      b.imm = 32'h0;
        endcase
        case (w[6:0])
            7'h37, 7'h17, 7'h13, 7'h33, 7'h03, 7'h6f, 7'h67: writes = 1'b1;
            default: writes = 1'b0;
        endcase
        b.wr_reg_n = !(writes && w[11:7] != 5'd0);
        b.rs1_data = reg_value(w[19:15]);
        b.rs2_data = reg_value(w[24:20]);
        return b;
    endfunction

    task automatic stop_with_error(input string reason);
        $display("Error: %s", reason);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected_value,
                               input logic [31:0] actual);
        if (actual !== expected_value) begin
            $display("Error: %s expected %h actual %h", name, expected_value, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Issued bundles, in order, against the expected queue
    always @(posedge clk) begin
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                stop_with_error("out_valid seen with no bundle outstanding");
            end else begin
                exp_now = exp_q.pop_front();
                check_value($sformatf("bundle %0d rd", issued), exp_now.rd, out_rd);
                check_value($sformatf("bundle %0d opcode", issued), exp_now.opcode, out_opcode);
                check_value($sformatf("bundle %0d funct3", issued), exp_now.funct3, out_funct3);
                check_value($sformatf("bundle %0d funct7", issued), exp_now.funct7, out_funct7);
                check_value($sformatf("bundle %0d csr_addr", issued), exp_now.csr_addr,
                            out_csr_addr);
                check_value($sformatf("bundle %0d imm", issued), exp_now.imm, out_imm);
                check_value($sformatf("bundle %0d wr_reg_n", issued), exp_now.wr_reg_n,
                            out_wr_reg_n);
                check_value($sformatf("bundle %0d rs1_data", issued), exp_now.rs1_data,
                            out_rs1_data);
                check_value($sformatf("bundle %0d rs2_data", issued), exp_now.rs2_data,
                            out_rs2_data);
                issued++;
                if (issued > OUT_CREDITS + returned) begin
                    stop_with_error("more bundles issued than downstream credits allow");
                end
            end
        end
    end

    // Upstream credit returns
    always @(posedge clk) begin
        if (!rst && in_credit) begin
            credit_returns++;
            if (credit_returns > sent) begin
                stop_with_error("in_credit pulse without a matching instruction");
            end
        end
    end

    // Execute unit model, one credit back per bundle after a random wait
    initial begin
        forever begin
            wait (issued > returned);
            rng_state = next_random(rng_state);
            repeat (rng_state[2:0]) @(posedge clk);
            @(posedge clk);
            #2 out_credit = 1'b1;
            @(posedge clk);
            #2 out_credit = 1'b0;
            returned++;
        end
    end

    initial begin
        #((NUM * 60 + SETUP_CYCLES) * 20);
        stop_with_error("watchdog expired before all bundles were issued");
    end

    initial begin
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_instr   = 32'h0;
        wb_en      = 1'b0;
        wb_addr    = 5'd0;
        wb_data    = 32'h0;
        out_credit = 1'b0;
        for (int i = 0; i < NUM; i++) begin
            expected[i] = reference_decode(prog[i]);
        end
        repeat (3) @(posedge clk);
        #2 rst = 1'b0;

        // Fill x1 to x31, the x0 write must be dropped
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            #2;
            wb_en   = 1'b1;
            wb_addr = i[4:0];
            wb_data = (i == 0) ? 32'hFFFFFFFF : reg_value(i[4:0]);
        end
        @(posedge clk);
        #2 wb_en = 1'b0;

        // Send only while a credit is held
        for (int idx = 0; idx < NUM; ) begin
            @(posedge clk);
            #2;
            if (IN_DEPTH - sent + credit_returns > 0) begin
                in_valid = 1'b1;
                in_instr = prog[idx];
                exp_q.push_back(expected[idx]);
                sent++;
                idx++;
            end else begin
                in_valid = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        in_instr = 32'h0;

        wait (issued == NUM && returned == NUM);
        repeat (5) @(posedge clk);
        check_value("upstream credits", NUM, credit_returns);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== source/decode_top.sv ====
`timescale 1ns/1ps

module decode_top import rv_decode_pkg::*; #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  instr_t    in_instr,
    output logic      in_credit,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  xlen_t     wb_data,
    input  logic      out_credit,
    output logic      out_valid,
    output reg_addr_t out_rd,
    output opcode_t   out_opcode,
    output funct3_t   out_funct3,
    output funct7_t   out_funct7,
    output csr_addr_t out_csr_addr,
    output xlen_t     out_imm,
    output logic      out_wr_reg_n,
    output xlen_t     out_rs1_data,
    output xlen_t     out_rs2_data
);

    // Decode register to operand stage
    logic      dec_valid;
    logic      dec_ready;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    reg_addr_t dec_rd;
    opcode_t   dec_opcode;
    funct3_t   dec_funct3;
    funct7_t   dec_funct7;
    csr_addr_t dec_csr_addr;
    xlen_t     dec_imm;
    logic      dec_wr_reg_n;

    // Register file read ports
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;

    id_stage #(
        .IN_DEPTH (IN_DEPTH)
    ) id_stage_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_instr     (in_instr),
        .in_credit    (in_credit),
        .dec_ready    (dec_ready),
        .dec_valid    (dec_valid),
        .dec_rs1      (dec_rs1),
        .dec_rs2      (dec_rs2),
        .dec_rd       (dec_rd),
        .dec_opcode   (dec_opcode),
        .dec_funct3   (dec_funct3),
        .dec_funct7   (dec_funct7),
        .dec_csr_addr (dec_csr_addr),
        .dec_imm      (dec_imm),
        .dec_wr_reg_n (dec_wr_reg_n)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    operand_stage #(
        .OUT_CREDITS (OUT_CREDITS)
    ) operand_stage_i (
        .clk          (clk),
        .rst          (rst),
        .dec_valid    (dec_valid),
        .dec_ready    (dec_ready),
        .dec_rs1      (dec_rs1),
        .dec_rs2      (dec_rs2),
        .dec_rd       (dec_rd),
        .dec_opcode   (dec_opcode),
        .dec_funct3   (dec_funct3),
        .dec_funct7   (dec_funct7),
        .dec_csr_addr (dec_csr_addr),
        .dec_imm      (dec_imm),
        .dec_wr_reg_n (dec_wr_reg_n),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .out_credit   (out_credit),
        .out_valid    (out_valid),
        .out_rd       (out_rd),
        .out_opcode   (out_opcode),
        .out_funct3   (out_funct3),
        .out_funct7   (out_funct7),
        .out_csr_addr (out_csr_addr),
        .out_imm      (out_imm),
        .out_wr_reg_n (out_wr_reg_n),
        .out_rs1_data (out_rs1_data),
        .out_rs2_data (out_rs2_data)
    );

endmodule

// ==== source/operand_stage.sv ====
`timescale 1ns/1ps

module operand_stage import rv_decode_pkg::*; #(
    parameter int OUT_CREDITS = 2
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      dec_valid,
    output logic      dec_ready,
    input  reg_addr_t dec_rs1,
    input  reg_addr_t dec_rs2,
    input  reg_addr_t dec_rd,
    input  opcode_t   dec_opcode,
    input  funct3_t   dec_funct3,
    input  funct7_t   dec_funct7,
    input  csr_addr_t dec_csr_addr,
    input  xlen_t     dec_imm,
    input  logic      dec_wr_reg_n,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  xlen_t     rs1_data,
    input  xlen_t     rs2_data,
    input  logic      out_credit,
    output logic      out_valid,
    output reg_addr_t out_rd,
    output opcode_t   out_opcode,
    output funct3_t   out_funct3,
    output funct7_t   out_funct7,
    output csr_addr_t out_csr_addr,
    output xlen_t     out_imm,
    output logic      out_wr_reg_n,
    output xlen_t     out_rs1_data,
    output xlen_t     out_rs2_data
);

    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic             out_pending;
    logic [CNT_W-1:0] credit_cnt;
    logic             capture;

    // Register file is read straight from the decode register
    assign rs1_addr = dec_rs1;
    assign rs2_addr = dec_rs2;

    // Issue needs a filled slot and a credit in hand
    assign out_valid = out_pending && (credit_cnt != '0);
    assign dec_ready = !out_pending || out_valid;
    assign capture   = dec_valid && dec_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_pending <= 1'b0;
        end else if (capture) begin
            out_pending <= 1'b1;
        end else if (out_valid) begin
            out_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            out_rd       <= dec_rd;
            out_opcode   <= dec_opcode;
            out_funct3   <= dec_funct3;
            out_funct7   <= dec_funct7;
            out_csr_addr <= dec_csr_addr;
            out_imm      <= dec_imm;
            out_wr_reg_n <= dec_wr_reg_n;
            out_rs1_data <= rs1_data;
            out_rs2_data <= rs2_data;
        end
    end

    // Returned credit and issue may land in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CNT_W'(OUT_CREDITS);
        end else begin
            credit_cnt <= credit_cnt + CNT_W'(out_credit) - CNT_W'(out_valid);
        end
    end

    // Execute unit never returns more than it was given
    assert property (@(posedge clk) disable iff (rst)
        int'(credit_cnt) <= OUT_CREDITS);

    // A credit comes back only for a bundle still outstanding
    assert property (@(posedge clk) disable iff (rst)
        out_credit |-> (int'(credit_cnt) < OUT_CREDITS));

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import rv_decode_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs1_data,
    output xlen_t     rs2_data,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  xlen_t     wb_data
);

    // x0 has no storage
    xlen_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // No bypass, a write shows up on the next cycle
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

    always_comb begin
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

// ==== source/id_stage.sv ====
`timescale 1ns/1ps

module id_stage import rv_decode_pkg::*; #(
    parameter int IN_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  instr_t    in_instr,
    output logic      in_credit,
    input  logic      dec_ready,
    output logic      dec_valid,
    output reg_addr_t dec_rs1,
    output reg_addr_t dec_rs2,
    output reg_addr_t dec_rd,
    output opcode_t   dec_opcode,
    output funct3_t   dec_funct3,
    output funct7_t   dec_funct7,
    output csr_addr_t dec_csr_addr,
    output xlen_t     dec_imm,
    output logic      dec_wr_reg_n
);

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);

    instr_t           queue_mem [IN_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             pop;

    instr_t    head;
    opcode_t   head_opcode;
    reg_addr_t head_rs1;
    reg_addr_t head_rs2;
    reg_addr_t head_rd;
    funct3_t   head_funct3;
    funct7_t   head_funct7;
    csr_addr_t head_csr_addr;
    imm_sel_t  head_imm_sel;
    xlen_t     head_imm;

    function automatic imm_sel_t imm_sel_from(opcode_t opcode, funct3_t funct3);
        case (opcode)
            op_lui, op_auipc:         return imm_u;
            op_jal:                   return imm_j;
            op_jalr, op_load:         return imm_i;
            op_branch:                return imm_b;
            op_store:                 return imm_s;
            // SLLI, SRLI and SRAI carry a shift amount
            op_imm:                   return (funct3 == 3'b001 || funct3 == 3'b101) ?
                                             imm_shamt : imm_i;
            default:                  return imm_none;
        endcase
    endfunction

    // Low means write; only listed opcodes may write, never x0
    function automatic logic wr_reg_n_from(opcode_t opcode, reg_addr_t rd);
        logic writes;
        writes = (opcode == op_lui) || (opcode == op_auipc) || (opcode == op_imm) ||
                 (opcode == op_reg) || (opcode == op_load) || (opcode == op_jal) ||
                 (opcode == op_jalr);
        return !(writes && rd != '0);
    endfunction

    // Head moves on when the decode register is free or being drained
    assign pop  = (fill != '0) && (!dec_valid || dec_ready);
    assign head = queue_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (in_valid) begin
            queue_mem[wr_ptr] <= in_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fill      <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill      <= fill + CNT_W'(in_valid) - CNT_W'(pop);
            // One slot freed, one credit back
            in_credit <= pop;
        end
    end

    ir_splitter ir_splitter_i (
        .ir       (head),
        .opcode   (head_opcode),
        .rs1      (head_rs1),
        .rs2      (head_rs2),
        .rd       (head_rd),
        .funct3   (head_funct3),
        .funct7   (head_funct7),
        .csr_addr (head_csr_addr)
    );

    assign head_imm_sel = imm_sel_from(head_opcode, head_funct3);

    imm_extractor imm_extractor_i (
        .in       (head),
        .imm_type (head_imm_sel),
        .out      (head_imm)
    );

    // Decode pipeline register
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (pop) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dec_rs1      <= head_rs1;
            dec_rs2      <= head_rs2;
            dec_rd       <= head_rd;
            dec_opcode   <= head_opcode;
            dec_funct3   <= head_funct3;
            dec_funct7   <= head_funct7;
            dec_csr_addr <= head_csr_addr;
            dec_imm      <= head_imm;
            dec_wr_reg_n <= wr_reg_n_from(head_opcode, head_rd);
        end
    end

    // Sender keeps to its credits, so the queue never overflows
    assert property (@(posedge clk) disable iff (rst)
        in_valid |-> (int'(fill) < IN_DEPTH));

endmodule

// ==== source/imm_extractor.sv ====
`timescale 1ns/1ps

module imm_extractor import rv_decode_pkg::*; (
    input  instr_t   in,
    input  imm_sel_t imm_type,
    output xlen_t    out
);

    // Sign bit is always instruction bit 31
    logic sign;

    assign sign = in[31];

    always_comb begin
        case (imm_type)
            imm_i: begin
                out = {{20{sign}}, in[31:20]};
            end
            imm_s: begin
                out = {{20{sign}}, in[31:25], in[11:7]};
            end
            imm_b: begin
                // Branch offsets are in half-words
                out = {{19{sign}}, sign, in[7], in[30:25], in[11:8], 1'b0};
            end
            imm_u: begin
                out = {in[31:12], 12'b0};
            end
            imm_j: begin
                out = {{11{sign}}, sign, in[19:12], in[20], in[30:21], 1'b0};
            end
            imm_shamt: begin
                // Shift amount only, upper bits hold funct7
                out = {27'b0, in[24:20]};
            end
            default: begin
                out = '0;
            end
        endcase
    end

endmodule

// ==== source/ir_splitter.sv ====
`timescale 1ns/1ps

module ir_splitter import rv_decode_pkg::*; (
    input  instr_t    ir,
    output opcode_t   opcode,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output funct3_t   funct3,
    output funct7_t   funct7,
    output csr_addr_t csr_addr
);

    // Fixed field positions, shared by all formats
    assign opcode = ir[6:0];
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign funct7 = ir[31:25];

    // Same bits as the I immediate, unsigned
    assign csr_addr = ir[31:20];

endmodule

// ==== source/rv_decode_pkg.sv ====
package rv_decode_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] instr_t;
    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [11:0] csr_addr_t;

    // Immediate format selector
    typedef logic [2:0]  imm_sel_t;

    localparam imm_sel_t imm_i     = 3'b000;
    localparam imm_sel_t imm_b     = 3'b001;
    localparam imm_sel_t imm_s     = 3'b010;
    localparam imm_sel_t imm_u     = 3'b011;
    localparam imm_sel_t imm_j     = 3'b100;
    localparam imm_sel_t imm_shamt = 3'b101;
    // 3'b110 is left unused
    localparam imm_sel_t imm_none  = 3'b111;

    // RV32I major opcodes
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg    = 7'b0110011;

endpackage
